//--- src.f
verilog/mmc5_cpu_pkg.sv
verilog/mmc5_ppu_pkg.sv
verilog/mmc5_regs.sv
verilog/mmc5_prg_map.sv
verilog/mmc5_chr_map.sv
verilog/mmc5_scanline.sv
verilog/mmc5_exram.sv
verilog/mmc5_top.sv
sim/mmc5_checker.sv
sim/mmc5_tb.sv

//--- Bender.yml
package:
  name: mmc5

sources:
  - verilog/mmc5_cpu_pkg.sv
  - verilog/mmc5_ppu_pkg.sv
  - verilog/mmc5_regs.sv
  - verilog/mmc5_prg_map.sv
  - verilog/mmc5_chr_map.sv
  - verilog/mmc5_scanline.sv
  - verilog/mmc5_exram.sv
  - verilog/mmc5_top.sv
  - target: simulation
    files:
      - sim/mmc5_checker.sv
      - sim/mmc5_tb.sv

//--- sim/mmc5_tb.sv
// MMC5 mapper testbench
`timescale 1ns/1ps
`default_nettype none

module mmc5_tb;

	localparam int TIMEOUT_CYCLES = 20000;	// Whole run needs well under 2000

	logic                    clk;
	logic                    rst_n_i;
	logic                    ce_i;
	mmc5_cpu_pkg::cpu_addr_t prg_ain_i;
	mmc5_cpu_pkg::cpu_data_t prg_din_i;
	logic                    prg_read_i;
	logic                    prg_write_i;
	mmc5_ppu_pkg::ppu_addr_t chr_ain_i;
	logic                    chr_read_i;
	mmc5_cpu_pkg::prg_out_t  prg_aout_o;
	mmc5_cpu_pkg::cpu_data_t prg_dout_o;
	logic                    prg_bus_drive_o;
	logic                    prg_allow_o;
	mmc5_ppu_pkg::chr_out_t  chr_aout_o;
	logic                    vram_a10_o;
	logic                    vram_ce_o;
	logic                    irq_o;

	integer seed = 32'h21e574c1;
	int     cycle_cnt = 0;

	// Register values as written by the stimulus
	logic [7:0] prg_bank_m [0:3];
	logic [2:0] prg_ram_bank_m;
	logic [9:0] chr_bank_m [0:7];
	logic [7:0] exram_m [0:15];
	logic [9:0] exram_addr_m [0:15];

	mmc5_top dut_i (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Watchdog and checker failures
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1);
		end else if (dut_i.checker_i.fail_count != 0) begin
			$display("A bound assertion on the mapper failed");
			$display("Test failed");
			$fatal(1);
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	// One CPU cycle every third clock
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		next_edge();
		prg_ain_i   = addr;
		prg_din_i   = data;
		prg_write_i = 1'b1;
		ce_i        = 1'b1;
		next_edge();
		ce_i        = 1'b0;
		prg_write_i = 1'b0;
		next_edge();
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data,
			output logic drive);
		next_edge();
		prg_ain_i  = addr;
		prg_read_i = 1'b1;
		ce_i       = 1'b1;
		next_edge();
		data       = prg_dout_o;	// ExRAM output has had one edge
		drive      = prg_bus_drive_o;
		ce_i       = 1'b0;
		prg_read_i = 1'b0;
		next_edge();
	endtask

	task automatic idle_cpu_cycle();
		next_edge();
		prg_ain_i = 16'h0000;
		ce_i      = 1'b1;
		next_edge();
		ce_i      = 1'b0;
		next_edge();
	endtask

	task automatic ppu_fetch(input logic [13:0] addr);
		next_edge();
		chr_ain_i  = addr;
		chr_read_i = 1'b1;	// Rising edge is the read event
		next_edge();
		chr_read_i = 1'b0;
	endtask

	// Larger windows keep the upper bank bits and take the rest from the address
	function automatic logic [21:0] expected_prg_addr(input logic [1:0] mode,
			input logic [15:0] addr);
		logic [1:0] idx;
		int         drop;
		logic [7:0] mask;
		logic [7:0] sel;
		idx  = addr[14:13];
		drop = 0;
		case (mode)
			2'd0: begin
				idx  = 2'd3;
				drop = 2;
			end
			2'd1: begin
				idx  = addr[14] ? 2'd3 : 2'd1;
				drop = 1;
			end
			2'd2: begin
				idx  = addr[14] ? {1'b1, addr[13]} : 2'd1;
				drop = addr[14] ? 0 : 1;
			end
			default: idx = addr[14:13];
		endcase
		mask = (8'd1 << drop) - 8'd1;
		sel  = (prg_bank_m[idx] & ~mask) | ({6'b0, addr[14:13]} & mask);
		if (!addr[15]) begin
			sel = {5'b0, prg_ram_bank_m};
		end
		if (sel[7]) begin
			return {2'b00, sel[6:0], addr[12:0]};
		end
		return {mmc5_cpu_pkg::PRG_RAM_TAG, sel[2:0], addr[12:0]};
	endfunction

	// CHR banks count in pages of the mode's size
	function automatic logic [21:0] expected_chr_addr(input logic [1:0] mode,
			input logic [13:0] addr);
		int         drop;
		logic [3:0] wide_mask;
		logic [2:0] mask;
		logic [2:0] idx;
		logic [9:0] sel;
		drop      = 3 - int'(mode);
		wide_mask = (4'd1 << drop) - 4'd1;
		mask      = wide_mask[2:0];
		idx       = addr[12:10] | mask;	// Highest bank of each page
		sel       = (chr_bank_m[idx] << drop) | {7'b0, addr[12:10] & mask};
		return {mmc5_ppu_pkg::CHR_ROM_TAG, sel, addr[9:0]};
	endfunction

	initial begin
		logic [7:0]  rd;
		logic        drv;
		logic [7:0]  mul_a;
		logic [7:0]  mul_b;
		logic [15:0] product;
		logic [7:0]  mirr;
		logic [9:0]  base;
		logic [13:0] paddr;
		int          n_lines;

		rst_n_i     = 1'b0;
		ce_i        = 1'b0;
		prg_ain_i   = '0;
		prg_din_i   = '0;
		prg_read_i  = 1'b0;
		prg_write_i = 1'b0;
		chr_ain_i   = '0;
		chr_read_i  = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		// Reset leaves the top window on the last ROM bank
		prg_ain_i = 16'hFFFC;
		#10;
		assert (prg_aout_o == {2'b00, 7'h7F, 13'h1FFC})
		else report_mismatch("reset_prg", {2'b00, 7'h7F, 13'h1FFC}, 32'(prg_aout_o));

		// PRG banking in every mode
		for (int m = 0; m < 4; m++) begin
			for (int b = 0; b < 4; b++) begin
				prg_bank_m[b] = 8'($random(seed));
			end
			prg_bank_m[3][7] = 1'b1;
			prg_ram_bank_m   = 3'($random(seed));
			bus_write(16'h5100, 8'(m));
			bus_write(16'h5113, {5'b0, prg_ram_bank_m});
			for (int b = 0; b < 4; b++) begin
				bus_write(16'h5114 + 16'(b), prg_bank_m[b]);
			end
			for (int w = 0; w < 8; w++) begin
				next_edge();
				prg_ain_i = {3'(w), 13'($random(seed))};
				#10;
				assert (prg_aout_o == expected_prg_addr(2'(m), prg_ain_i))
				else report_mismatch("prg_bank", 32'(expected_prg_addr(2'(m), prg_ain_i)),
					32'(prg_aout_o));
			end
		end

		// PRG-RAM protection, judged by the checker
		bus_write(16'h6000, 8'hA5);
		bus_write(16'h5102, 8'h02);
		bus_write(16'h5103, 8'h01);
		bus_write(16'h6000, 8'h5A);
		bus_write(16'hE000, 8'h5A);	// Always a ROM bank
		bus_write(16'h5102, 8'h00);

		// CHR banking in every mode
		for (int m = 0; m < 4; m++) begin
			bus_write(16'h5101, 8'(m));
			for (int k = 0; k < 8; k++) begin
				chr_bank_m[k] = 10'($random(seed));
				bus_write(16'h5130, {6'b0, chr_bank_m[k][9:8]});
				bus_write(16'h5120 + 16'(k), chr_bank_m[k][7:0]);
			end
			for (int r = 0; r < 8; r++) begin
				next_edge();
				chr_ain_i = {1'b0, 3'(r), 10'($random(seed))};
				#10;
				assert (chr_aout_o == expected_chr_addr(2'(m), chr_ain_i))
				else report_mismatch("chr_bank", 32'(expected_chr_addr(2'(m), chr_ain_i)),
					32'(chr_aout_o));
			end
		end

		// Nametable mirroring per quadrant
		mirr = 8'($random(seed));
		bus_write(16'h5105, mirr);
		for (int q = 0; q < 4; q++) begin
			next_edge();
			chr_ain_i = {2'b10, 2'(q), 10'($random(seed))};
			#10;
			assert (vram_a10_o == mirr[2 * q])
			else report_mismatch("vram_a10", 32'(mirr[2 * q]), 32'(vram_a10_o));
			assert (vram_ce_o == !mirr[2 * q + 1])
			else report_mismatch("vram_ce", 32'(!mirr[2 * q + 1]), 32'(vram_ce_o));
		end

		// Multiplier
		mul_a   = 8'($random(seed));
		mul_b   = 8'($random(seed));
		product = 16'(mul_a) * 16'(mul_b);
		bus_write(16'h5205, mul_a);
		bus_write(16'h5206, mul_b);
		bus_read(16'h5205, rd, drv);
		assert (rd == product[7:0]) else report_mismatch("mul_lo", 32'(product[7:0]), 32'(rd));
		assert (drv) else report_mismatch("mul_lo_drive", 32'd1, 32'(drv));
		bus_read(16'h5206, rd, drv);
		assert (rd == product[15:8]) else report_mismatch("mul_hi", 32'(product[15:8]), 32'(rd));
		assert (drv) else report_mismatch("mul_hi_drive", 32'd1, 32'(drv));
		bus_read(16'h8000, rd, drv);
		assert (!drv) else report_mismatch("open_bus_drive", 32'd0, 32'(drv));

		// ExRAM as CPU RAM, then as ROM
		bus_write(16'h5104, 8'h02);
		base = 10'($random(seed));
		for (int i = 0; i < 16; i++) begin
			exram_addr_m[i] = base + 10'(i * 61);	// Odd stride gives distinct addresses
			exram_m[i]      = 8'($random(seed));
			bus_write({mmc5_cpu_pkg::EXRAM_PAGE, exram_addr_m[i]}, exram_m[i]);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read({mmc5_cpu_pkg::EXRAM_PAGE, exram_addr_m[i]}, rd, drv);
			assert (rd == exram_m[i]) else report_mismatch("exram_rw", 32'(exram_m[i]), 32'(rd));
		end
		bus_write(16'h5104, 8'h03);
		for (int i = 0; i < 16; i++) begin
			bus_write({mmc5_cpu_pkg::EXRAM_PAGE, exram_addr_m[i]}, ~exram_m[i]);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read({mmc5_cpu_pkg::EXRAM_PAGE, exram_addr_m[i]}, rd, drv);
			assert (rd == exram_m[i]) else report_mismatch("exram_ro", 32'(exram_m[i]), 32'(rd));
		end

		// Scanline IRQ
		n_lines = ($random(seed) & 7) + 1;
		paddr   = {4'b1000, 10'($random(seed))};
		bus_write(16'h5203, 8'(n_lines));
		bus_write(16'h5204, 8'h80);
		repeat (4 + n_lines) ppu_fetch(paddr);	// Three repeats, then one read per line
		next_edge();
		assert (irq_o == 1'b1) else report_mismatch("scanline_irq", 32'd1, 32'(irq_o));
		bus_read(16'h5204, rd, drv);
		assert (rd[7:6] == 2'b11) else report_mismatch("status", 32'h3, 32'(rd[7:6]));
		idle_cpu_cycle();
		assert (irq_o == 1'b0) else report_mismatch("irq_ack", 32'd0, 32'(irq_o));
		idle_cpu_cycle();	// Third idle CPU cycle ends the frame
		bus_read(16'h5204, rd, drv);
		assert (rd[6] == 1'b0) else report_mismatch("frame_exit", 32'd0, 32'(rd[6]));

		repeat (3) next_edge();
		if (dut_i.checker_i.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- sim/mmc5_checker.sv
// MMC5 bound assertions
`timescale 1ns/1ps
`default_nettype none

module mmc5_checker (
	input wire                          clk,
	input wire                          rst_n_i,
	input wire                          ce_i,
	input wire mmc5_cpu_pkg::cpu_addr_t prg_ain_i,
	input wire                          prg_write_i,
	input wire mmc5_cpu_pkg::prg_out_t  prg_aout_o,
	input wire                          prg_allow_o,
	input wire                          irq_o,
	input wire                          ram_we_ok_i,
	input wire                          status_read_i,
	input wire                          irq_pending_i,
	input wire                          in_frame_i
);

	int unsigned fail_count = 0;	// Polled by the testbench

	// Allowed writes land in unlocked PRG-RAM at $6000 and above only
	write_needs_ram: assert property (@(posedge clk) disable iff (!rst_n_i)
		prg_write_i && prg_allow_o
		|-> prg_ain_i >= 16'h6000 && ram_we_ok_i
			&& prg_aout_o[21:16] == mmc5_cpu_pkg::PRG_RAM_TAG)
	else begin
		$error("Write allowed below 0x6000, to ROM or to locked PRG-RAM");
		fail_count++;
	end

	unlocked_ram_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		ram_we_ok_i && prg_write_i && prg_ain_i[15:13] == 3'b011 |-> prg_allow_o)
	else begin
		$error("Write to unlocked PRG-RAM at 0x6000 was refused");
		fail_count++;
	end

	// Acknowledge takes effect on the CPU cycle after the status read
	irq_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		status_read_i |=> ce_i [->1] ##1 !irq_pending_i)
	else begin
		$error("IRQ pending not cleared after the status read");
		fail_count++;
	end

	reset_quiet: assert property (@(posedge clk)
		!rst_n_i |=> !irq_o && !in_frame_i)
	else begin
		$error("IRQ or in-frame active right after reset");
		fail_count++;
	end

endmodule

bind mmc5_top mmc5_checker checker_i (
	.clk, .rst_n_i, .ce_i, .prg_ain_i, .prg_write_i, .prg_aout_o, .prg_allow_o, .irq_o,
	.ram_we_ok_i   (ram_we_ok),
	.status_read_i (status_read),
	.irq_pending_i (irq_pending),
	.in_frame_i    (in_frame)
);

`default_nettype wire

//--- verilog/mmc5_top.sv
// MMC5 mapper top level
`timescale 1ns/1ps
`default_nettype none

module mmc5_top (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           ce_i,
	input  wire mmc5_cpu_pkg::cpu_addr_t  prg_ain_i,
	input  wire mmc5_cpu_pkg::cpu_data_t  prg_din_i,
	input  wire                           prg_read_i,
	input  wire                           prg_write_i,
	input  wire mmc5_ppu_pkg::ppu_addr_t  chr_ain_i,
	input  wire                           chr_read_i,
	output mmc5_cpu_pkg::prg_out_t        prg_aout_o,
	output mmc5_cpu_pkg::cpu_data_t       prg_dout_o,
	output logic                          prg_bus_drive_o,
	output logic                          prg_allow_o,
	output mmc5_ppu_pkg::chr_out_t        chr_aout_o,
	output logic                          vram_a10_o,
	output logic                          vram_ce_o,
	output logic                          irq_o
);

	mmc5_cpu_pkg::prg_mode_t       prg_mode;
	mmc5_cpu_pkg::prg_bank_t [3:0] prg_bank;
	logic [2:0]                    prg_ram_bank;
	logic                          ram_we_ok;
	mmc5_ppu_pkg::chr_mode_t       chr_mode;
	mmc5_ppu_pkg::chr_bank_t [7:0] chr_bank;
	logic [7:0]                    mirroring;
	mmc5_ppu_pkg::exram_mode_t     exram_mode;
	mmc5_ppu_pkg::scanline_t       irq_scanline;
	logic                          irq_enable;
	logic                          status_read;
	logic                          in_frame;
	logic                          irq_pending;
	mmc5_cpu_pkg::cpu_data_t       exram_rd_data;

	mmc5_regs regs_i (
		.clk, .rst_n_i, .ce_i, .prg_ain_i, .prg_din_i, .prg_read_i, .prg_write_i,
		.in_frame_i      (in_frame),
		.irq_pending_i   (irq_pending),
		.exram_rd_data_i (exram_rd_data),
		.prg_mode_o      (prg_mode),
		.prg_bank_o      (prg_bank),
		.prg_ram_bank_o  (prg_ram_bank),
		.ram_we_ok_o     (ram_we_ok),
		.chr_mode_o      (chr_mode),
		.chr_bank_o      (chr_bank),
		.mirroring_o     (mirroring),
		.exram_mode_o    (exram_mode),
		.irq_scanline_o  (irq_scanline),
		.irq_enable_o    (irq_enable),
		.status_read_o   (status_read),
		.prg_dout_o, .prg_bus_drive_o
	);

	mmc5_prg_map prg_map_i (
		.prg_ain_i, .prg_write_i,
		.prg_mode_i     (prg_mode),
		.prg_bank_i     (prg_bank),
		.prg_ram_bank_i (prg_ram_bank),
		.ram_we_ok_i    (ram_we_ok),
		.prg_aout_o, .prg_allow_o
	);

	mmc5_chr_map chr_map_i (
		.chr_ain_i,
		.chr_mode_i  (chr_mode),
		.chr_bank_i  (chr_bank),
		.mirroring_i (mirroring),
		.chr_aout_o, .vram_a10_o, .vram_ce_o
	);

	mmc5_scanline scanline_i (
		.clk, .rst_n_i, .ce_i, .prg_ain_i, .prg_read_i, .chr_ain_i, .chr_read_i,
		.irq_scanline_i (irq_scanline),
		.status_read_i  (status_read),
		.in_frame_o     (in_frame),
		.irq_pending_o  (irq_pending)
	);

	mmc5_exram exram_i (
		.clk, .rst_n_i, .ce_i, .prg_ain_i, .prg_din_i, .prg_write_i,
		.in_frame_i   (in_frame),
		.exram_mode_i (exram_mode),
		.rd_data_o    (exram_rd_data)
	);

	assign irq_o = irq_pending && irq_enable;	// Pending stays visible in $5204

endmodule

`default_nettype wire

//--- verilog/mmc5_exram.sv
// MMC5 expansion RAM
`timescale 1ns/1ps
`default_nettype none

module mmc5_exram (
	input  wire                              clk,
	input  wire                              rst_n_i,
	input  wire                              ce_i,
	input  wire mmc5_cpu_pkg::cpu_addr_t     prg_ain_i,
	input  wire mmc5_cpu_pkg::cpu_data_t     prg_din_i,
	input  wire                              prg_write_i,
	input  wire                              in_frame_i,
	input  wire mmc5_ppu_pkg::exram_mode_t   exram_mode_i,
	output mmc5_cpu_pkg::cpu_data_t          rd_data_o
);

	mmc5_cpu_pkg::cpu_data_t   mem [0:1023];
	mmc5_ppu_pkg::exram_addr_t addr;
	logic                      we;

	assign addr = prg_ain_i[9:0];

	// Mode 3 is read-only
	assign we = ce_i && prg_write_i && prg_ain_i[15:10] == mmc5_cpu_pkg::EXRAM_PAGE
		&& exram_mode_i != 2'd3;

	// Nametable modes store zero outside the frame
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= (exram_mode_i[1] || in_frame_i) ? prg_din_i : 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_data_o <= '0;
		end else begin
			rd_data_o <= mem[addr];	// One cycle read latency
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmc5_scanline.sv
// MMC5 scanline detector and IRQ
`timescale 1ns/1ps
`default_nettype none

module mmc5_scanline (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           ce_i,
	input  wire mmc5_cpu_pkg::cpu_addr_t  prg_ain_i,
	input  wire                           prg_read_i,
	input  wire mmc5_ppu_pkg::ppu_addr_t  chr_ain_i,
	input  wire                           chr_read_i,
	input  wire mmc5_ppu_pkg::scanline_t  irq_scanline_i,
	input  wire                           status_read_i,
	output logic                          in_frame_o,
	output logic                          irq_pending_o
);

	logic                    chr_read_q;
	logic                    read_event;
	logic [11:0]             last_nt_addr_q;
	logic [1:0]              nt_cnt_q;	// Identical nametable reads seen
	logic [1:0]              idle_cnt_q;	// CPU cycles without a PPU read
	mmc5_ppu_pkg::scanline_t scanline_q;
	logic                    in_frame_d_q;
	logic                    pending_clr_q;
	logic                    vector_read;

	assign read_event = chr_read_i && !chr_read_q;

	// NMI vector fetch means the CPU is in vblank
	assign vector_read = ce_i && prg_read_i
		&& {prg_ain_i[15:1], 1'b0} == mmc5_cpu_pkg::ADDR_NMI_VEC;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			chr_read_q     <= 1'b0;
			last_nt_addr_q <= '0;
			nt_cnt_q       <= '0;
			idle_cnt_q     <= '0;
			scanline_q     <= '0;
			in_frame_o     <= 1'b0;
			in_frame_d_q   <= 1'b0;
			irq_pending_o  <= 1'b0;
			pending_clr_q  <= 1'b0;
		end else begin
			chr_read_q   <= chr_read_i;
			in_frame_d_q <= in_frame_o;

			if (read_event) begin
				last_nt_addr_q <= chr_ain_i[11:0];
				if (nt_cnt_q != mmc5_ppu_pkg::NT_REPEAT) begin
					nt_cnt_q <= nt_cnt_q + 2'd1;
				end else if (!in_frame_o) begin
					in_frame_o <= 1'b1;
					scanline_q <= '0;
				end else if (scanline_q == mmc5_ppu_pkg::LAST_SCANLINE) begin
					in_frame_o <= 1'b0;
				end else begin
					scanline_q <= scanline_q + 8'd1;
					if (scanline_q + 8'd1 == irq_scanline_i) begin
						irq_pending_o <= 1'b1;
					end
				end
				// Any other read breaks the run
				if (chr_ain_i[13:12] != 2'b10
						|| (nt_cnt_q != 2'd0 && last_nt_addr_q != chr_ain_i[11:0])) begin
					nt_cnt_q <= '0;
				end
			end

			if (ce_i) begin
				if (chr_read_i) begin
					idle_cnt_q <= '0;
				end else if (in_frame_o) begin
					idle_cnt_q <= idle_cnt_q + 2'd1;
					if (idle_cnt_q == mmc5_ppu_pkg::CPU_IDLE_LIMIT) begin
						in_frame_o <= 1'b0;	// PPU stopped rendering
					end
				end
				if (pending_clr_q) begin
					irq_pending_o <= 1'b0;
					pending_clr_q <= 1'b0;
				end
				if (status_read_i) begin
					pending_clr_q <= 1'b1;
				end
			end

			if (vector_read) begin
				in_frame_o <= 1'b0;
			end

			// Falling edge of in_frame
			if (in_frame_d_q && !in_frame_o) begin
				nt_cnt_q      <= '0;
				idle_cnt_q    <= '0;
				irq_pending_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmc5_chr_map.sv
// MMC5 CHR bank and nametable mapping
`timescale 1ns/1ps
`default_nettype none

module mmc5_chr_map (
	input  wire mmc5_ppu_pkg::ppu_addr_t       chr_ain_i,
	input  wire mmc5_ppu_pkg::chr_mode_t       chr_mode_i,
	input  wire mmc5_ppu_pkg::chr_bank_t [7:0] chr_bank_i,
	input  wire [7:0]                          mirroring_i,
	output mmc5_ppu_pkg::chr_out_t             chr_aout_o,
	output logic                               vram_a10_o,
	output logic                               vram_ce_o
);

	mmc5_ppu_pkg::chr_bank_t sel;	// Selected 1 kB bank
	logic [1:0]              nt_field;

	// Larger pages drop low bank bits in favour of address bits
	always_comb begin
		case (chr_mode_i)
			2'd0: begin
				// One 8 kB page
				sel = {chr_bank_i[7][6:0], chr_ain_i[12:10]};
			end
			2'd1: begin
				// Two 4 kB pages from banks 3 and 7
				sel = {chr_bank_i[{chr_ain_i[12], 2'b11}][7:0], chr_ain_i[11:10]};
			end
			2'd2: begin
				// Four 2 kB pages from the odd banks
				sel = {chr_bank_i[{chr_ain_i[12:11], 1'b1}][8:0], chr_ain_i[10]};
			end
			default: begin
				sel = chr_bank_i[chr_ain_i[12:10]];	// Eight 1 kB pages
			end
		endcase
	end

	assign chr_aout_o = {mmc5_ppu_pkg::CHR_ROM_TAG, sel, chr_ain_i[9:0]};

	// Two bits per nametable quadrant
	// 00 VRAM page A, 01 VRAM page B, 1x not routed to VRAM
	assign nt_field = mirroring_i[{chr_ain_i[11:10], 1'b0} +: 2];

	assign vram_a10_o = nt_field[0];
	assign vram_ce_o  = chr_ain_i[13] && !nt_field[1];

endmodule

`default_nettype wire

//--- verilog/mmc5_prg_map.sv
// MMC5 PRG bank mapping
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_map (
	input  wire mmc5_cpu_pkg::cpu_addr_t       prg_ain_i,
	input  wire                                prg_write_i,
	input  wire mmc5_cpu_pkg::prg_mode_t       prg_mode_i,
	input  wire mmc5_cpu_pkg::prg_bank_t [3:0] prg_bank_i,
	input  wire [2:0]                          prg_ram_bank_i,
	input  wire                                ram_we_ok_i,
	output mmc5_cpu_pkg::prg_out_t             prg_aout_o,
	output logic                               prg_allow_o
);

	mmc5_cpu_pkg::prg_bank_t sel;	// Selected 8 kB bank

	always_comb begin
		sel = {5'b00000, prg_ram_bank_i};	// $6000-$7FFF in every mode
		if (prg_ain_i[15]) begin
			case (prg_mode_i)
				2'd0: sel = {prg_bank_i[3][7:2], prg_ain_i[14:13]};	// 32 kB
				2'd1: begin
					// Two 16 kB windows
					if (prg_ain_i[14]) begin
						sel = {prg_bank_i[3][7:1], prg_ain_i[13]};
					end else begin
						sel = {prg_bank_i[1][7:1], prg_ain_i[13]};
					end
				end
				2'd2: begin
					if (prg_ain_i[14]) begin
						sel = prg_bank_i[{1'b1, prg_ain_i[13]}];	// 8 kB at $C000/$E000
					end else begin
						sel = {prg_bank_i[1][7:1], prg_ain_i[13]};
					end
				end
				default: sel = prg_bank_i[prg_ain_i[14:13]];	// Four 8 kB windows
			endcase
		end
	end

	assign prg_aout_o = sel[7] ? {2'b00, sel[6:0], prg_ain_i[12:0]}
		: {mmc5_cpu_pkg::PRG_RAM_TAG, sel[2:0], prg_ain_i[12:0]};

	// Writes only reach unprotected RAM
	assign prg_allow_o = prg_ain_i >= 16'h6000 && (!prg_write_i || (!sel[7] && ram_we_ok_i));

endmodule

`default_nettype wire

//--- verilog/mmc5_regs.sv
// MMC5 register file
`timescale 1ns/1ps
`default_nettype none

module mmc5_regs (
	input  wire                                 clk,
	input  wire                                 rst_n_i,
	input  wire                                 ce_i,
	input  wire mmc5_cpu_pkg::cpu_addr_t        prg_ain_i,
	input  wire mmc5_cpu_pkg::cpu_data_t        prg_din_i,
	input  wire                                 prg_read_i,
	input  wire                                 prg_write_i,
	input  wire                                 in_frame_i,
	input  wire                                 irq_pending_i,
	input  wire mmc5_cpu_pkg::cpu_data_t        exram_rd_data_i,
	output mmc5_cpu_pkg::prg_mode_t             prg_mode_o,
	output mmc5_cpu_pkg::prg_bank_t [3:0]       prg_bank_o,
	output logic [2:0]                          prg_ram_bank_o,
	output logic                                ram_we_ok_o,
	output mmc5_ppu_pkg::chr_mode_t             chr_mode_o,
	output mmc5_ppu_pkg::chr_bank_t [7:0]       chr_bank_o,
	output logic [7:0]                          mirroring_o,
	output mmc5_ppu_pkg::exram_mode_t           exram_mode_o,
	output mmc5_ppu_pkg::scanline_t             irq_scanline_o,
	output logic                                irq_enable_o,
	output logic                                status_read_o,
	output mmc5_cpu_pkg::cpu_data_t             prg_dout_o,
	output logic                                prg_bus_drive_o
);

	mmc5_cpu_pkg::prg_bank_t [2:0] prg_bank_q;
	logic [6:0]                    prg_bank3_q;	// Always ROM
	logic [1:0]                    protect1_q;
	logic [1:0]                    protect2_q;
	logic [1:0]                    chr_upper_q;
	mmc5_cpu_pkg::cpu_data_t       mul_a_q;
	mmc5_cpu_pkg::cpu_data_t       mul_b_q;
	logic [15:0]                   product;
	logic                          reg_write;

	assign reg_write = ce_i && prg_write_i && prg_ain_i[15:10] == mmc5_cpu_pkg::REG_PAGE;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			prg_mode_o     <= 2'd3;
			prg_bank_q     <= '0;
			prg_bank3_q    <= 7'h7F;
			prg_ram_bank_o <= '0;
			protect1_q     <= '0;
			protect2_q     <= '0;
			chr_mode_o     <= '0;
			chr_bank_o     <= '0;
			chr_upper_q    <= '0;
			mirroring_o    <= '0;
			exram_mode_o   <= '0;
			irq_scanline_o <= '0;
			irq_enable_o   <= 1'b0;
			mul_a_q        <= '0;
			mul_b_q        <= '0;
		end else if (reg_write) begin
			case (prg_ain_i[9:0])
				mmc5_cpu_pkg::REG_PRG_MODE:     prg_mode_o     <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_CHR_MODE:     chr_mode_o     <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_PROTECT1:     protect1_q     <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_PROTECT2:     protect2_q     <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_EXRAM_MODE:   exram_mode_o   <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_MIRRORING:    mirroring_o    <= prg_din_i;
				mmc5_cpu_pkg::REG_PRG_RAM_BANK: prg_ram_bank_o <= prg_din_i[2:0];
				mmc5_cpu_pkg::REG_PRG_BANK0:    prg_bank_q[0]  <= prg_din_i;
				mmc5_cpu_pkg::REG_PRG_BANK1:    prg_bank_q[1]  <= prg_din_i;
				mmc5_cpu_pkg::REG_PRG_BANK2:    prg_bank_q[2]  <= prg_din_i;
				mmc5_cpu_pkg::REG_PRG_BANK3:    prg_bank3_q    <= prg_din_i[6:0];
				mmc5_cpu_pkg::REG_CHR_UPPER:    chr_upper_q    <= prg_din_i[1:0];
				mmc5_cpu_pkg::REG_IRQ_SCANLINE: irq_scanline_o <= prg_din_i;
				mmc5_cpu_pkg::REG_IRQ_STATUS:   irq_enable_o   <= prg_din_i[7];
				mmc5_cpu_pkg::REG_MUL_A:        mul_a_q        <= prg_din_i;
				mmc5_cpu_pkg::REG_MUL_B:        mul_b_q        <= prg_din_i;
				default: begin
					// Sprite bank set $5120-$5127 takes the latched upper bits
					if (prg_ain_i[9:3] == mmc5_cpu_pkg::REG_CHR_BANK_BASE[9:3]) begin
						chr_bank_o[prg_ain_i[2:0]] <= {chr_upper_q, prg_din_i};
					end
				end
			endcase
		end
	end

	assign prg_bank_o  = {{1'b1, prg_bank3_q}, prg_bank_q[2], prg_bank_q[1], prg_bank_q[0]};
	assign ram_we_ok_o = protect1_q == 2'b10 && protect2_q == 2'b01;

	assign product = mul_a_q * mul_b_q;	// Unsigned 8x8

	// Status read clears IRQ pending in the scanline block
	assign status_read_o = ce_i && prg_read_i && prg_ain_i == mmc5_cpu_pkg::ADDR_STATUS;

	always_comb begin
		prg_dout_o      = 8'hFF;	// Open bus
		prg_bus_drive_o = 1'b1;
		if (prg_ain_i[15:10] == mmc5_cpu_pkg::EXRAM_PAGE && exram_mode_o[1]) begin
			prg_dout_o = exram_rd_data_i;
		end else if (prg_ain_i == mmc5_cpu_pkg::ADDR_STATUS) begin
			prg_dout_o = {irq_pending_i, in_frame_i, 6'b111111};
		end else if (prg_ain_i == mmc5_cpu_pkg::ADDR_MUL_LO) begin
			prg_dout_o = product[7:0];
		end else if (prg_ain_i == mmc5_cpu_pkg::ADDR_MUL_HI) begin
			prg_dout_o = product[15:8];
		end else begin
			prg_bus_drive_o = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmc5_ppu_pkg.sv
// MMC5 PPU-side definitions
`default_nettype none

package mmc5_ppu_pkg;

	typedef logic [13:0] ppu_addr_t;	// PPU address bus
	typedef logic [1:0]  chr_mode_t;
	typedef logic [9:0]  chr_bank_t;	// 1 kB bank, upper bits from $5130
	typedef logic [21:0] chr_out_t;

	// ExRAM modes
	// 0/1 nametable use, writable only in frame
	// 2 CPU RAM, 3 CPU ROM
	typedef logic [1:0] exram_mode_t;
	typedef logic [9:0] exram_addr_t;

	typedef logic [7:0] scanline_t;

	// Scanline detection
	localparam logic [7:0] LAST_SCANLINE  = 8'd239;
	localparam logic [1:0] NT_REPEAT      = 2'd3;	// Identical nametable reads per line end
	localparam logic [1:0] CPU_IDLE_LIMIT = 2'd2;	// Idle CPU cycles before frame ends

	localparam logic [1:0] CHR_ROM_TAG = 2'b10;	// CHR region of the output

endpackage

`default_nettype wire

//--- verilog/mmc5_cpu_pkg.sv
// MMC5 CPU-side definitions
`default_nettype none

package mmc5_cpu_pkg;

	typedef logic [15:0] cpu_addr_t;	// CPU address bus
	typedef logic [7:0]  cpu_data_t;
	typedef logic [1:0]  prg_mode_t;
	typedef logic [7:0]  prg_bank_t;	// Bit 7 set selects ROM
	typedef logic [21:0] prg_out_t;

	// Pages decoded from A15-A10
	localparam logic [5:0] REG_PAGE   = 6'b010100;	// $5000-$53FF
	localparam logic [5:0] EXRAM_PAGE = 6'b010111;	// $5C00-$5FFF

	// Register offsets inside REG_PAGE
	localparam logic [9:0] REG_PRG_MODE      = 10'h100;
	localparam logic [9:0] REG_CHR_MODE      = 10'h101;
	localparam logic [9:0] REG_PROTECT1      = 10'h102;
	localparam logic [9:0] REG_PROTECT2      = 10'h103;
	localparam logic [9:0] REG_EXRAM_MODE    = 10'h104;
	localparam logic [9:0] REG_MIRRORING     = 10'h105;
	localparam logic [9:0] REG_PRG_RAM_BANK  = 10'h113;
	localparam logic [9:0] REG_PRG_BANK0     = 10'h114;
	localparam logic [9:0] REG_PRG_BANK1     = 10'h115;
	localparam logic [9:0] REG_PRG_BANK2     = 10'h116;
	localparam logic [9:0] REG_PRG_BANK3     = 10'h117;
	localparam logic [9:0] REG_CHR_BANK_BASE = 10'h120;	// Eight sprite banks
	localparam logic [9:0] REG_CHR_UPPER     = 10'h130;
	localparam logic [9:0] REG_IRQ_SCANLINE  = 10'h203;
	localparam logic [9:0] REG_IRQ_STATUS    = 10'h204;
	localparam logic [9:0] REG_MUL_A         = 10'h205;
	localparam logic [9:0] REG_MUL_B         = 10'h206;

	// Full addresses for read-back
	localparam logic [15:0] ADDR_STATUS  = 16'h5204;
	localparam logic [15:0] ADDR_MUL_LO  = 16'h5205;
	localparam logic [15:0] ADDR_MUL_HI  = 16'h5206;
	localparam logic [15:0] ADDR_NMI_VEC = 16'hFFFA;

	localparam logic [5:0] PRG_RAM_TAG = 6'b111100;	// PRG-RAM region of the output

endpackage

`default_nettype wire
